//--- verilog/dai_reg_pkg.sv
// Direct-access register map of the fuse controller.
// Offsets, data width and the fuse command opcodes seen on the core's write bus.
package dai_reg_pkg;

    // --------------------
    // Widths
    // --------------------

    // Only the low address bits select a direct-access register.
    localparam int unsigned DAI_OFFSET_W = 12;
    // Data words are 32 bits. The AXI address bus uses the same width.
    localparam int unsigned DAI_DATA_W = 32;

    // --------------------
    // Register offsets
    // --------------------

    localparam logic [DAI_OFFSET_W-1:0] DAI_CMD_OFFSET     = 12'h060;
    localparam logic [DAI_OFFSET_W-1:0] DAI_ADDRESS_OFFSET = 12'h064;
    localparam logic [DAI_OFFSET_W-1:0] DAI_WDATA0_OFFSET  = 12'h068;
    localparam logic [DAI_OFFSET_W-1:0] DAI_WDATA1_OFFSET  = 12'h06C;

    // Fuse opcodes written to CMD. Any other value is an unknown command.
    typedef enum logic [DAI_DATA_W-1:0] {
        DaiRead    = 32'h0000_0001,
        DaiWrite   = 32'h0000_0002,
        DaiDigest  = 32'h0000_0004,
        DaiZeroize = 32'h0000_0008
    } dai_cmd_e;

    // Register targeted by an address handshake.
    typedef enum logic [2:0] {
        REG_NONE,
        REG_WDATA0,
        REG_WDATA1,
        REG_ADDRESS,
        REG_CMD
    } dai_reg_e;

endpackage

//--- verilog/fuse_policy_pkg.sv
// Fuse write policy definitions.
// Range ownership table and the states of the command filter.
package fuse_policy_pkg;

    import dai_reg_pkg::*;

    // Agent that may program a fuse range.
    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_CORE,
        OWNER_MCU
    } fuse_owner_e;

    // One entry of the ownership table. Both bounds are inclusive.
    typedef struct packed {
        logic [DAI_DATA_W-1:0] lower;
        logic [DAI_DATA_W-1:0] upper;
        fuse_owner_e           owner;
    } fuse_range_t;

    // --------------------
    // Ownership table
    // --------------------

    localparam int unsigned FUSE_NUM_RANGES = 3;

    // Entries do not overlap. Addresses outside all of them have no owner.
    localparam fuse_range_t FUSE_RANGE_TABLE [0:FUSE_NUM_RANGES-1] = '{
        '{lower: 32'h0000_0000, upper: 32'h0000_00FF, owner: OWNER_CORE},
        '{lower: 32'h0000_0100, upper: 32'h0000_02FF, owner: OWNER_MCU},
        '{lower: 32'h0000_0300, upper: 32'h0000_03FF, owner: OWNER_MCU}
    };

    // --------------------
    // Filter states
    // --------------------

    typedef enum logic [1:0] {
        WAIT_INIT,
        IDLE,
        CMD_PENDING,
        DISCARD
    } filter_state_e;

endpackage

//--- verilog/dai_write_decoder.sv
// Direct-access write decoder.
// Turns AXI write handshakes into per-register address and data strobes.
`timescale 1ns/1ps

module dai_write_decoder
    import dai_reg_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  aw_valid_i,
    input  logic                  aw_ready_i,
    input  logic [DAI_DATA_W-1:0] aw_addr_i,
    input  logic                  w_valid_i,
    input  logic                  w_ready_i,
    output dai_reg_e              aw_reg_o,
    output logic                  addr_data_stb_o,
    output logic                  cmd_data_stb_o
);

    logic                    aw_event;
    logic                    w_event;
    logic [DAI_OFFSET_W-1:0] aw_offset;
    dai_reg_e                aw_target;
    dai_reg_e                last_reg_q;

    assign aw_event  = aw_valid_i & aw_ready_i;
    assign w_event   = w_valid_i & w_ready_i;
    assign aw_offset = aw_addr_i[DAI_OFFSET_W-1:0];

    // Map the register offset onto the register it selects.
    always_comb begin
        case (aw_offset)
            DAI_WDATA0_OFFSET:  aw_target = REG_WDATA0;
            DAI_WDATA1_OFFSET:  aw_target = REG_WDATA1;
            DAI_ADDRESS_OFFSET: aw_target = REG_ADDRESS;
            DAI_CMD_OFFSET:     aw_target = REG_CMD;
            default:            aw_target = REG_NONE;
        endcase
    end

    assign aw_reg_o = aw_event ? aw_target : REG_NONE;

    // Remember where the last address handshake went, so that the next
    // data beat can be matched to its register. A data beat consumes it.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_reg_q <= REG_NONE;
        end else if (aw_event) begin
            last_reg_q <= aw_target;
        end else if (w_event) begin
            last_reg_q <= REG_NONE;
        end
    end

    assign addr_data_stb_o = w_event && (last_reg_q == REG_ADDRESS);
    assign cmd_data_stb_o  = w_event && (last_reg_q == REG_CMD);

endmodule

//--- verilog/requester_id_tracker.sv
// Requester ID tracker.
// Records the AXI user ID of each register phase and compares them.
`timescale 1ns/1ps

module requester_id_tracker
    import dai_reg_pkg::*;
#(
    parameter int unsigned USER_W = 32
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dai_reg_e          aw_reg_i,
    input  logic [USER_W-1:0] aw_user_i,
    input  logic              records_clear_i,
    output logic              ids_all_same_o,
    output logic              addr_cmd_same_o,
    output logic [USER_W-1:0] cmd_user_o
);

    logic [USER_W-1:0] data0_id_q;
    logic [USER_W-1:0] data1_id_q;
    logic [USER_W-1:0] addr_id_q;
    logic [USER_W-1:0] cmd_id_q;

    // A clear wins over a load in the same cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data0_id_q <= '0;
            data1_id_q <= '0;
            addr_id_q  <= '0;
            cmd_id_q   <= '0;
        end else if (records_clear_i) begin
            data0_id_q <= '0;
            data1_id_q <= '0;
            addr_id_q  <= '0;
            cmd_id_q   <= '0;
        end else begin
            case (aw_reg_i)
                REG_WDATA0:  data0_id_q <= aw_user_i;
                REG_WDATA1:  data1_id_q <= aw_user_i;
                REG_ADDRESS: addr_id_q  <= aw_user_i;
                REG_CMD:     cmd_id_q   <= aw_user_i;
                default:     ;
            endcase
        end
    end

    // A skipped phase leaves its record at zero and so breaks the match.
    assign addr_cmd_same_o = (addr_id_q == cmd_id_q);
    assign ids_all_same_o  = (data0_id_q == data1_id_q) && (data1_id_q == addr_id_q)
                             && addr_cmd_same_o;
    assign cmd_user_o      = cmd_id_q;

endmodule

//--- verilog/fuse_range_checker.sv
// Fuse range checker.
// Captures the fuse address word and finds the owner of the range holding it.
`timescale 1ns/1ps

module fuse_range_checker
    import dai_reg_pkg::*;
    import fuse_policy_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  addr_data_stb_i,
    input  logic [DAI_DATA_W-1:0] w_data_i,
    input  logic                  records_clear_i,
    output fuse_owner_e           range_owner_o
);

    logic [DAI_DATA_W-1:0] fuse_addr_q;
    logic                  found;

    // --------------------
    // Address capture
    // --------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fuse_addr_q <= '0;
        end else if (records_clear_i) begin
            fuse_addr_q <= '0;
        end else if (addr_data_stb_i) begin
            fuse_addr_q <= w_data_i;
        end
    end

    // --------------------
    // Table lookup
    // --------------------

    // Walk the table in order. The first entry that contains the address
    // gives the owner, later hits are ignored.
    always_comb begin
        range_owner_o = OWNER_NONE;
        found         = 1'b0;
        for (int i = 0; i < FUSE_NUM_RANGES; i++) begin
            if (!found
                && (fuse_addr_q >= FUSE_RANGE_TABLE[i].lower)
                && (fuse_addr_q <= FUSE_RANGE_TABLE[i].upper)) begin
                range_owner_o = FUSE_RANGE_TABLE[i].owner;
                found         = 1'b1;
            end
        end
    end

endmodule

//--- verilog/fuse_cmd_filter_fsm.sv
// Fuse command filter FSM.
// Decides at the command data beat whether the fuse command is discarded.
`timescale 1ns/1ps

module fuse_cmd_filter_fsm
    import dai_reg_pkg::*;
    import fuse_policy_pkg::*;
#(
    parameter int unsigned USER_W = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  init_done_i,
    input  dai_reg_e              aw_reg_i,
    input  logic                  cmd_data_stb_i,
    input  logic [DAI_DATA_W-1:0] w_data_i,
    input  logic                  ids_all_same_i,
    input  logic                  addr_cmd_same_i,
    input  logic [USER_W-1:0]     cmd_user_i,
    input  fuse_owner_e           range_owner_i,
    input  logic [USER_W-1:0]     core_user_i,
    input  logic [USER_W-1:0]     mcu_user_i,
    input  logic                  discarded_i,
    output logic                  records_clear_o,
    output logic                  discard_o
);

    filter_state_e state_q;
    filter_state_e state_d;
    dai_cmd_e      cmd_op;
    logic          range_ok;
    logic          violation;
    logic          discard_d;

    assign cmd_op = dai_cmd_e'(w_data_i);

    // The range check passes only if the owner's strap matches the command ID.
    always_comb begin
        case (range_owner_i)
            OWNER_CORE: range_ok = (core_user_i == cmd_user_i);
            OWNER_MCU:  range_ok = (mcu_user_i == cmd_user_i);
            default:    range_ok = 1'b0;
        endcase
    end

    // Reads and unknown opcodes always go through.
    always_comb begin
        case (cmd_op)
            DaiWrite:   violation = !(range_ok && ids_all_same_i);
            DaiDigest:  violation = !(range_ok && addr_cmd_same_i);
            DaiZeroize: violation = !(range_ok && addr_cmd_same_i);
            default:    violation = 1'b0;
        endcase
    end

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_d         = state_q;
        records_clear_o = 1'b0;
        discard_d       = 1'b0;
        case (state_q)
            WAIT_INIT: begin
                // Records are held clear so nothing seen before init counts.
                records_clear_o = 1'b1;
                if (init_done_i) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                if (aw_reg_i == REG_CMD) begin
                    state_d = CMD_PENDING;
                end
            end
            CMD_PENDING: begin
                if (cmd_data_stb_i) begin
                    records_clear_o = 1'b1;
                    discard_d       = violation;
                    state_d         = violation ? DISCARD : IDLE;
                end
            end
            DISCARD: begin
                discard_d = !discarded_i;
                if (discarded_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = WAIT_INIT;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= WAIT_INIT;
            discard_o <= 1'b0;
        end else begin
            state_q   <= state_d;
            discard_o <= discard_d;
        end
    end

endmodule

//--- verilog/fuse_write_filter.sv
// Fuse write filter top level.
// Watches direct-access register writes and discards fuse commands that break policy.
`timescale 1ns/1ps

module fuse_write_filter
    import dai_reg_pkg::*;
    import fuse_policy_pkg::*;
#(
    parameter int unsigned USER_W = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // AXI write address channel, observed only.
    input  logic                  aw_valid_i,
    input  logic                  aw_ready_i,
    input  logic [DAI_DATA_W-1:0] aw_addr_i,
    input  logic [USER_W-1:0]     aw_user_i,
    // AXI write data channel, observed only.
    input  logic                  w_valid_i,
    input  logic                  w_ready_i,
    input  logic [DAI_DATA_W-1:0] w_data_i,
    // Strap IDs of the two agents.
    input  logic [USER_W-1:0]     core_user_i,
    input  logic [USER_W-1:0]     mcu_user_i,
    // Fuse controller side.
    input  logic                  init_done_i,
    input  logic                  discarded_i,
    output logic                  discard_o
);

    dai_reg_e          aw_reg;
    logic              addr_data_stb;
    logic              cmd_data_stb;
    logic              ids_all_same;
    logic              addr_cmd_same;
    logic [USER_W-1:0] cmd_user;
    fuse_owner_e       range_owner;
    logic              records_clear;

    dai_write_decoder u_decoder (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .aw_valid_i      (aw_valid_i),
        .aw_ready_i      (aw_ready_i),
        .aw_addr_i       (aw_addr_i),
        .w_valid_i       (w_valid_i),
        .w_ready_i       (w_ready_i),
        .aw_reg_o        (aw_reg),
        .addr_data_stb_o (addr_data_stb),
        .cmd_data_stb_o  (cmd_data_stb)
    );

    // The tracker and the checker work side by side on the decoder strobes.
    requester_id_tracker #(
        .USER_W (USER_W)
    ) u_id_tracker (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .aw_reg_i        (aw_reg),
        .aw_user_i       (aw_user_i),
        .records_clear_i (records_clear),
        .ids_all_same_o  (ids_all_same),
        .addr_cmd_same_o (addr_cmd_same),
        .cmd_user_o      (cmd_user)
    );

    fuse_range_checker u_range_checker (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .addr_data_stb_i (addr_data_stb),
        .w_data_i        (w_data_i),
        .records_clear_i (records_clear),
        .range_owner_o   (range_owner)
    );

    fuse_cmd_filter_fsm #(
        .USER_W (USER_W)
    ) u_filter_fsm (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .init_done_i     (init_done_i),
        .aw_reg_i        (aw_reg),
        .cmd_data_stb_i  (cmd_data_stb),
        .w_data_i        (w_data_i),
        .ids_all_same_i  (ids_all_same),
        .addr_cmd_same_i (addr_cmd_same),
        .cmd_user_i      (cmd_user),
        .range_owner_i   (range_owner),
        .core_user_i     (core_user_i),
        .mcu_user_i      (mcu_user_i),
        .discarded_i     (discarded_i),
        .records_clear_o (records_clear),
        .discard_o       (discard_o)
    );

endmodule

//--- testbench/tb_clk_gen.sv
// Testbench clock and reset generator.
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset is released a little after an edge, like every other input.
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule

//--- testbench/fuse_write_filter_assert.sv
// Concurrent checks on the discard output of the fuse write filter.
`timescale 1ns/1ps

module fuse_write_filter_assert
    import fuse_policy_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  filter_state_e state_i,
    input  logic          cmd_data_stb_i,
    input  logic          discarded_i,
    input  logic          discard_i
);

    // Number of failed assertions so far.
    int fail_count = 0;

    // Nothing can be discarded before the fuse controller is initialized.
    a_low_before_init: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == WAIT_INIT) |-> !discard_i)
        else begin
            fail_count++;
            $error("discard_o high while the filter waits for init");
        end

    // A discard ends only after the controller acknowledged it.
    a_fall_after_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(discard_i) |-> $past(discarded_i))
        else begin
            fail_count++;
            $error("discard_o fell without an acknowledge the cycle before");
        end

    a_rise_after_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(discard_i) |-> $past(cmd_data_stb_i))
        else begin
            fail_count++;
            $error("discard_o rose without a command data beat the cycle before");
        end

endmodule

//--- testbench/fuse_write_filter_tb.sv
// Testbench for the fuse write filter.
// Drives register write sequences and checks discard_o against a reference model.
`timescale 1ns/1ps

module fuse_write_filter_tb
    import dai_reg_pkg::*;
;

    localparam int unsigned USER_W     = 32;
    localparam int unsigned MAX_CYCLES = 6000;
    localparam logic [31:0] CORE_ID    = 32'h0000_0C01;
    localparam logic [31:0] MCU_ID     = 32'h0000_0A02;
    localparam logic [31:0] STRAY_ID   = 32'h0000_0F03;
    localparam logic [31:0] REG_BASE   = 32'h2000_0000;

    logic              clk;
    logic              rst_n;
    logic              aw_valid;
    logic              aw_ready;
    logic [31:0]       aw_addr;
    logic [USER_W-1:0] aw_user;
    logic              w_valid;
    logic              w_ready;
    logic [31:0]       w_data;
    logic              init_done;
    logic              discarded;
    logic              discard;
    // High during the data beat of a CMD write.
    logic              cmd_beat;
    logic              exp_q[$];
    logic              exp_val;
    int                checks;
    int                errors;
    int                test_errors;
    int                cycle_count;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fuse_write_filter #(.USER_W(USER_W)) dut0 (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .aw_valid_i  (aw_valid),
        .aw_ready_i  (aw_ready),
        .aw_addr_i   (aw_addr),
        .aw_user_i   (aw_user),
        .w_valid_i   (w_valid),
        .w_ready_i   (w_ready),
        .w_data_i    (w_data),
        .core_user_i (CORE_ID),
        .mcu_user_i  (MCU_ID),
        .init_done_i (init_done),
        .discarded_i (discarded),
        .discard_o   (discard)
    );

    bind fuse_write_filter fuse_write_filter_assert u_discard_assert (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .state_i        (u_filter_fsm.state_q),
        .cmd_data_stb_i (cmd_data_stb),
        .discarded_i    (discarded_i),
        .discard_i      (discard_o)
    );

    // --------------------
    // Reference model
    // --------------------

    // Skipped phases are passed in as zero, which is what a cleared record holds.
    function automatic logic expected_discard(input logic [31:0] op, input logic [31:0] addr,
                                              input logic [31:0] id0, input logic [31:0] id1,
                                              input logic [31:0] ida, input logic [31:0] idc);
        logic        owned;
        logic [31:0] owner_id;
        logic        range_ok;
        logic        all_same;
        owned    = 1'b1;
        owner_id = '0;
        if (addr <= 32'h0FF) begin
            owner_id = CORE_ID;
        end else if (addr <= 32'h3FF) begin
            owner_id = MCU_ID;
        end else begin
            owned = 1'b0;
        end
        range_ok = owned && (owner_id == idc);
        all_same = (id0 == id1) && (id1 == ida) && (ida == idc);
        case (op)
            32'h2:        return !(range_ok && all_same);
            32'h4, 32'h8: return !(range_ok && (ida == idc));
            default:      return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] pick_id();
        case ($urandom_range(0, 2))
            0:       return CORE_ID;
            1:       return MCU_ID;
            default: return STRAY_ID;
        endcase
    endfunction

    // --------------------
    // Bus tasks
    // --------------------

    // One AW event, one W event, then an idle cycle.
    task automatic write_reg(input logic [DAI_OFFSET_W-1:0] offset,
                             input logic [USER_W-1:0] user,
                             input logic [31:0] data, input logic is_cmd);
        @(posedge clk);
        #2;
        aw_valid = 1'b1;
        aw_ready = 1'b1;
        aw_addr  = REG_BASE | offset;
        aw_user  = user;
        @(posedge clk);
        #2;
        aw_valid = 1'b0;
        aw_ready = 1'b0;
        w_valid  = 1'b1;
        w_ready  = 1'b1;
        w_data   = data;
        cmd_beat = is_cmd;
        @(posedge clk);
        #2;
        w_valid  = 1'b0;
        w_ready  = 1'b0;
        cmd_beat = 1'b0;
    endtask

    // Checks that the discard holds, then acknowledges it.
    task automatic release_discard();
        repeat (2) begin
            @(posedge clk);
            #2;
            checks++;
            if (discard !== 1'b1) begin
                $display("MISMATCH discard_o: expected 0x1, got 0x%0h before acknowledge",
                         discard);
                errors++;
                test_errors++;
            end
        end
        discarded = 1'b1;
        @(posedge clk);
        #2;
        discarded = 1'b0;
        checks++;
        if (discard !== 1'b0) begin
            $display("MISMATCH discard_o: expected 0x0, got 0x%0h after acknowledge", discard);
            errors++;
            test_errors++;
        end
    endtask

    // skip bits: [0] WDATA_0, [1] WDATA_1, [2] ADDRESS.
    task automatic run_seq(input logic [31:0] op, input logic [31:0] addr,
                           input logic [31:0] id0, input logic [31:0] id1,
                           input logic [31:0] ida, input logic [31:0] idc,
                           input logic [2:0] skip);
        logic exp;
        exp = expected_discard(op, skip[2] ? 32'h0 : addr, skip[0] ? 32'h0 : id0,
                               skip[1] ? 32'h0 : id1, skip[2] ? 32'h0 : ida, idc);
        if (!init_done) begin
            exp = 1'b0;
        end
        if (!skip[0]) write_reg(DAI_WDATA0_OFFSET, id0, 32'hA5A5_0000 ^ addr, 1'b0);
        if (!skip[1]) write_reg(DAI_WDATA1_OFFSET, id1, 32'h5A5A_0000 ^ addr, 1'b0);
        if (!skip[2]) write_reg(DAI_ADDRESS_OFFSET, ida, addr, 1'b0);
        exp_q.push_back(exp);
        write_reg(DAI_CMD_OFFSET, idc, op, 1'b1);
        if (discard === 1'b1) begin
            release_discard();
        end
    endtask

    task automatic run_random(input int count);
        logic [31:0] id;
        logic [31:0] op;
        logic [31:0] addr;
        logic [2:0]  skip;
        logic        same;
        for (int n = 0; n < count; n++) begin
            id   = pick_id();
            same = $urandom_range(0, 1);
            case ($urandom_range(0, 5))
                0:       op = DaiRead;
                1, 2:    op = DaiWrite;
                3:       op = DaiDigest;
                4:       op = DaiZeroize;
                default: op = $urandom;
            endcase
            addr = ($urandom_range(0, 7) == 0) ? $urandom : $urandom_range(0, 32'h47F);
            for (int b = 0; b < 3; b++) begin
                skip[b] = ($urandom_range(0, 7) == 0);
            end
            if (same) begin
                run_seq(op, addr, id, id, id, id, skip);
            end else begin
                run_seq(op, addr, pick_id(), pick_id(), pick_id(), id, skip);
            end
        end
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, test_errors);
        test_errors = 0;
    endtask

    // --------------------
    // Compare and watchdog
    // --------------------

    always @(posedge clk) begin
        if (cmd_beat) begin
            #1;
            if (exp_q.size() == 0) begin
                $display("A command beat completed with no expected result queued");
                errors++;
                test_errors++;
            end else begin
                exp_val = exp_q.pop_front();
                checks++;
                if (discard !== exp_val) begin
                    $display("MISMATCH discard_o: expected 0x%0h, got 0x%0h", exp_val, discard);
                    errors++;
                    test_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(85624));
        aw_valid    = 1'b0;
        aw_ready    = 1'b0;
        aw_addr     = '0;
        aw_user     = '0;
        w_valid     = 1'b0;
        w_ready     = 1'b0;
        w_data      = '0;
        init_done   = 1'b0;
        discarded   = 1'b0;
        cmd_beat    = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        cycle_count = 0;
        wait (rst_n === 1'b1);

        run_seq(DaiWrite, 32'h010, MCU_ID, MCU_ID, MCU_ID, MCU_ID, 3'b000);
        run_seq(DaiZeroize, 32'h500, STRAY_ID, CORE_ID, MCU_ID, STRAY_ID, 3'b000);
        finish_test(1, "no discard before init");
        init_done = 1'b1;
        @(posedge clk);
        #2;

        run_seq(DaiWrite, 32'h040, CORE_ID, CORE_ID, CORE_ID, CORE_ID, 3'b000);
        run_seq(DaiWrite, 32'h040, MCU_ID, MCU_ID, MCU_ID, MCU_ID, 3'b000);
        run_seq(DaiWrite, 32'h400, CORE_ID, CORE_ID, CORE_ID, CORE_ID, 3'b000);
        run_seq(DaiWrite, 32'h3FF, MCU_ID, MCU_ID, MCU_ID, MCU_ID, 3'b000);
        finish_test(2, "write range ownership");

        run_seq(DaiWrite, 32'h080, CORE_ID, STRAY_ID, CORE_ID, CORE_ID, 3'b000);
        // A stale WDATA_1 record of the core would let the next Write through.
        run_seq(DaiWrite, 32'h080, CORE_ID, CORE_ID, CORE_ID, CORE_ID, 3'b000);
        run_seq(DaiWrite, 32'h080, CORE_ID, CORE_ID, CORE_ID, CORE_ID, 3'b010);
        finish_test(3, "write ID consistency");

        run_seq(DaiDigest, 32'h150, STRAY_ID, CORE_ID, MCU_ID, MCU_ID, 3'b000);
        run_seq(DaiZeroize, 32'h020, MCU_ID, STRAY_ID, CORE_ID, CORE_ID, 3'b000);
        run_seq(DaiDigest, 32'h150, MCU_ID, MCU_ID, CORE_ID, MCU_ID, 3'b000);
        run_seq(DaiZeroize, 32'h500, CORE_ID, CORE_ID, CORE_ID, CORE_ID, 3'b000);
        run_seq(DaiDigest, 32'h030, MCU_ID, MCU_ID, MCU_ID, MCU_ID, 3'b000);
        run_seq(DaiZeroize, 32'h030, CORE_ID, CORE_ID, CORE_ID, CORE_ID, 3'b100);
        finish_test(4, "digest and zeroize");

        run_seq(DaiRead, 32'h900, STRAY_ID, CORE_ID, MCU_ID, STRAY_ID, 3'b000);
        run_seq(32'h0000_0010, 32'h050, STRAY_ID, STRAY_ID, MCU_ID, CORE_ID, 3'b000);
        run_seq(32'h0000_0003, 32'h200, CORE_ID, MCU_ID, STRAY_ID, MCU_ID, 3'b000);
        run_seq(32'h0000_0000, 32'h000, STRAY_ID, STRAY_ID, STRAY_ID, STRAY_ID, 3'b111);
        finish_test(5, "read and unknown opcodes");

        run_random(200);
        finish_test(6, "random sequences");

        if (dut0.u_discard_assert.fail_count != 0) begin
            $display("%0d assertion failures on discard_o", dut0.u_discard_assert.fail_count);
        end
        errors = errors + dut0.u_discard_assert.fail_count;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/dai_reg_pkg.sv
verilog/fuse_policy_pkg.sv
verilog/dai_write_decoder.sv
verilog/requester_id_tracker.sv
verilog/fuse_range_checker.sv
verilog/fuse_cmd_filter_fsm.sv
verilog/fuse_write_filter.sv
testbench/tb_clk_gen.sv
testbench/fuse_write_filter_assert.sv
testbench/fuse_write_filter_tb.sv

//--- Bender.yml
package:
  name: fuse_write_filter

sources:
  # Packages first, then the design from the leaves up to the top level.
  - files:
      - verilog/dai_reg_pkg.sv
      - verilog/fuse_policy_pkg.sv
      - verilog/dai_write_decoder.sv
      - verilog/requester_id_tracker.sv
      - verilog/fuse_range_checker.sv
      - verilog/fuse_cmd_filter_fsm.sv
      - verilog/fuse_write_filter.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/fuse_write_filter_assert.sv
      - testbench/fuse_write_filter_tb.sv
